//--- verilog/dma_bridge_defs.svh
// Size constants for the cache DMA to memory command bridge
`ifndef DMA_BRIDGE_DEFS_SVH
`define DMA_BRIDGE_DEFS_SVH

// Cache DMA ports sharing the memory channel
`define DMA_NUM_PORTS 2

// One data word on the cache side
`define DMA_WORD_W 32

// Words per cache block, sent whole on the memory side
`define DMA_BLOCK_WORDS 4

// Physical address width
`define DMA_ADDR_W 28

// Outstanding reads tracked by the response router
`define DMA_TAG_DEPTH 8

`endif

//--- verilog/dma_bridge_pkg.sv
// Packet, command, response and index types for the DMA to memory bridge
`default_nettype none
`include "dma_bridge_defs.svh"

package dma_bridge_pkg;

  // Port index width, kept at least one bit
  localparam int port_idx_w = (`DMA_NUM_PORTS > 1) ? $clog2(`DMA_NUM_PORTS) : 1;

  typedef logic [port_idx_w-1:0] port_idx_t;

  typedef logic [`DMA_WORD_W-1:0] word_t;

  // Word 0 sits in the low bits
  typedef word_t [`DMA_BLOCK_WORDS-1:0] block_t;

  // Cache side DMA request
  typedef struct packed {
    logic                   write_not_read;
    logic [`DMA_ADDR_W-1:0] addr;
  } dma_pkt_t;

  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WB = 1'b1
  } mem_op_e;

  // Memory command, data is zero on reads
  typedef struct packed {
    mem_op_e                op;
    logic [`DMA_ADDR_W-1:0] addr;
    block_t                 data;
  } mem_cmd_t;

  typedef struct packed {
    mem_op_e op;
    block_t  data;
  } mem_resp_t;

endpackage

`default_nettype wire

//--- verilog/dma_two_fifo.sv
// Two-entry FIFO of any element type with valid/ready in and valid/yumi out
`timescale 1ns/1ps
`default_nettype none

module dma_two_fifo
  #(parameter type elem_t = logic [31:0])
  (input  logic  clk_i
  ,input  logic  reset_i
  ,input  logic  v_i
  ,input  elem_t data_i
  ,output logic  ready_o
  ,output logic  v_o
  ,output elem_t data_o
  ,input  logic  yumi_i
  );

  elem_t mem_r [2];
  logic  wr_ptr_r;
  logic  rd_ptr_r;
  logic  full_r;
  logic  empty_r;
  logic  enq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ~full_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (yumi_i)
        rd_ptr_r <= ~rd_ptr_r;
      // Occupancy only changes when one side moves alone
      if (enq & ~yumi_i)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wr_ptr_r == rd_ptr_r);
      end
      else if (yumi_i & ~enq)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rd_ptr_r == wr_ptr_r);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

`default_nettype wire

//--- verilog/dma_rr_arbiter.sv
// Round-robin pick of one queued DMA packet across the cache ports
`timescale 1ns/1ps
`default_nettype none
`include "dma_bridge_defs.svh"

module dma_rr_arbiter
  (input  logic                                          clk_i
  ,input  logic                                          reset_i
  ,input  logic [`DMA_NUM_PORTS-1:0]                     v_i
  ,input  dma_bridge_pkg::dma_pkt_t [`DMA_NUM_PORTS-1:0] pkt_i
  ,output logic [`DMA_NUM_PORTS-1:0]                     yumi_o
  ,output logic                                          v_o
  ,output dma_bridge_pkg::dma_pkt_t                      pkt_o
  ,output dma_bridge_pkg::port_idx_t                     idx_o
  ,input  logic                                          yumi_i
  );

  dma_bridge_pkg::port_idx_t last_r;
  dma_bridge_pkg::port_idx_t sel;
  logic                      found;

  // Search starts just after the last winner
  always_comb
  begin
    int cand;
    found = 1'b0;
    sel   = last_r;
    for (int off = 1; off <= `DMA_NUM_PORTS; off++)
    begin
      cand = (int'(last_r) + off) % `DMA_NUM_PORTS;
      if (!found && v_i[cand])
      begin
        found = 1'b1;
        sel   = dma_bridge_pkg::port_idx_t'(cand);
      end
    end
  end

  assign v_o   = found;
  assign pkt_o = pkt_i[sel];
  assign idx_o = sel;

  always_comb
  begin
    yumi_o      = '0;
    yumi_o[sel] = yumi_i & found;
  end

  // Port 0 wins first after reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      last_r <= dma_bridge_pkg::port_idx_t'(`DMA_NUM_PORTS - 1);
    else if (yumi_i)
      last_r <= sel;
  end

endmodule

`default_nettype wire

//--- verilog/dma_cmd_builder.sv
// FSM that turns granted DMA packets into full-block memory commands
`timescale 1ns/1ps
`default_nettype none
`include "dma_bridge_defs.svh"

module dma_cmd_builder
  (input  logic                      clk_i
  ,input  logic                      reset_i
  ,input  logic                      pkt_v_i
  ,input  dma_bridge_pkg::dma_pkt_t  pkt_i
  ,input  dma_bridge_pkg::port_idx_t idx_i
  ,output logic                      pkt_yumi_o
  ,input  logic                      tag_ready_i
  ,output logic                      tag_v_o
  ,output dma_bridge_pkg::port_idx_t tag_o
  ,output dma_bridge_pkg::port_idx_t idx_o
  ,input  logic                      data_v_i
  ,input  dma_bridge_pkg::word_t     data_i
  ,output logic                      data_yumi_o
  ,output dma_bridge_pkg::mem_cmd_t  cmd_o
  ,output logic                      cmd_v_o
  ,input  logic                      cmd_yumi_i
  );

  localparam int cnt_w = (`DMA_BLOCK_WORDS > 1) ? $clog2(`DMA_BLOCK_WORDS) : 1;

  typedef enum logic [1:0] {
    ST_RESET,
    ST_READY,
    ST_GATHER,
    ST_SEND
  } state_e;

  state_e                    state_r;
  state_e                    state_n;
  dma_bridge_pkg::dma_pkt_t  pkt_r;
  dma_bridge_pkg::port_idx_t idx_r;
  dma_bridge_pkg::block_t    block_r;
  logic [cnt_w-1:0]          count_r;
  logic                      grant;
  logic                      last_word;

  // Reads also need a free slot in the router's tag queue
  assign grant = (state_r == ST_READY) & pkt_v_i & (pkt_i.write_not_read | tag_ready_i);

  assign pkt_yumi_o  = grant;
  assign tag_v_o     = grant & ~pkt_i.write_not_read;
  assign tag_o       = idx_i;
  assign idx_o       = idx_r;
  assign data_yumi_o = (state_r == ST_GATHER) & data_v_i;
  assign last_word   = data_yumi_o & (count_r == cnt_w'(`DMA_BLOCK_WORDS - 1));
  assign cmd_v_o     = (state_r == ST_SEND);

  always_comb
  begin
    cmd_o.op   = pkt_r.write_not_read ? dma_bridge_pkg::MEM_WB : dma_bridge_pkg::MEM_RD;
    cmd_o.addr = pkt_r.addr;
    cmd_o.data = pkt_r.write_not_read ? block_r : '0;
  end

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      ST_RESET:
        state_n = ST_READY;
      ST_READY:
        if (grant)
          state_n = pkt_i.write_not_read ? ST_GATHER : ST_SEND;
      ST_GATHER:
        if (last_word)
          state_n = ST_SEND;
      ST_SEND:
        if (cmd_yumi_i)
          state_n = ST_READY;
      default:
        state_n = ST_RESET;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= ST_RESET;
      count_r <= '0;
      idx_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (grant)
        idx_r <= idx_i;
      if (last_word)
        count_r <= '0;
      else if (data_yumi_o)
        count_r <= count_r + 1'b1;
    end
  end

  // Packet and block payload
  always_ff @(posedge clk_i)
  begin
    if (grant)
      pkt_r <= pkt_i;
    if (data_yumi_o)
      block_r[count_r] <= data_i;
  end

endmodule

`default_nettype wire

//--- verilog/dma_resp_router.sv
// Splits memory read responses into words and returns them to the requesting port
`timescale 1ns/1ps
`default_nettype none
`include "dma_bridge_defs.svh"

module dma_resp_router
  (input  logic                                       clk_i
  ,input  logic                                       reset_i
  ,input  logic                                       tag_v_i
  ,input  dma_bridge_pkg::port_idx_t                  tag_i
  ,output logic                                       tag_ready_o
  ,input  logic                                       resp_v_i
  ,input  dma_bridge_pkg::mem_resp_t                  resp_i
  ,output logic                                       resp_ready_o
  ,output dma_bridge_pkg::word_t [`DMA_NUM_PORTS-1:0] data_o
  ,output logic [`DMA_NUM_PORTS-1:0]                  data_v_o
  ,input  logic [`DMA_NUM_PORTS-1:0]                  data_ready_i
  );

  localparam int tag_ptr_w  = (`DMA_TAG_DEPTH > 1) ? $clog2(`DMA_TAG_DEPTH) : 1;
  localparam int word_cnt_w = (`DMA_BLOCK_WORDS > 1) ? $clog2(`DMA_BLOCK_WORDS) : 1;

  // Requesting ports of outstanding reads, oldest at the read pointer
  dma_bridge_pkg::port_idx_t tag_mem [`DMA_TAG_DEPTH];
  logic [tag_ptr_w-1:0]      tag_wr_ptr_r;
  logic [tag_ptr_w-1:0]      tag_rd_ptr_r;
  logic [tag_ptr_w:0]        tag_count_r;
  logic                      tag_push;
  logic                      tag_pop;
  dma_bridge_pkg::port_idx_t head_idx;

  dma_bridge_pkg::mem_resp_t fifo_resp;
  logic                      fifo_v;
  logic                      fifo_yumi;
  logic                      resp_is_rd;

  dma_bridge_pkg::block_t    shift_r;
  logic                      shift_v_r;
  logic [word_cnt_w-1:0]     word_cnt_r;
  logic                      shift_load;
  logic                      word_xfer;
  logic                      last_word;

  function automatic logic [tag_ptr_w-1:0] next_ptr(input logic [tag_ptr_w-1:0] ptr);
    return (ptr == tag_ptr_w'(`DMA_TAG_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  dma_two_fifo
    #(.elem_t(dma_bridge_pkg::mem_resp_t))
    resp_fifo
    (.clk_i  (clk_i)
    ,.reset_i(reset_i)
    ,.v_i    (resp_v_i)
    ,.data_i (resp_i)
    ,.ready_o(resp_ready_o)
    ,.v_o    (fifo_v)
    ,.data_o (fifo_resp)
    ,.yumi_i (fifo_yumi)
    );

  assign tag_ready_o = (tag_count_r != (tag_ptr_w + 1)'(`DMA_TAG_DEPTH));
  assign tag_push    = tag_v_i & tag_ready_o;
  assign head_idx    = tag_mem[tag_rd_ptr_r];

  assign word_xfer = shift_v_r & data_ready_i[head_idx];
  assign last_word = word_xfer & (word_cnt_r == word_cnt_w'(`DMA_BLOCK_WORDS - 1));
  assign tag_pop   = last_word;

  // Write-back responses drain at once, reads wait for the shifter
  assign resp_is_rd = (fifo_resp.op == dma_bridge_pkg::MEM_RD);
  assign shift_load = fifo_v & resp_is_rd & (~shift_v_r | last_word);
  assign fifo_yumi  = fifo_v & (~resp_is_rd | shift_load);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tag_wr_ptr_r <= '0;
      tag_rd_ptr_r <= '0;
      tag_count_r  <= '0;
    end
    else
    begin
      if (tag_push)
        tag_wr_ptr_r <= next_ptr(tag_wr_ptr_r);
      if (tag_pop)
        tag_rd_ptr_r <= next_ptr(tag_rd_ptr_r);
      if (tag_push & ~tag_pop)
        tag_count_r <= tag_count_r + 1'b1;
      else if (tag_pop & ~tag_push)
        tag_count_r <= tag_count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (tag_push)
      tag_mem[tag_wr_ptr_r] <= tag_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      shift_v_r  <= 1'b0;
      word_cnt_r <= '0;
    end
    else if (shift_load)
    begin
      shift_v_r  <= 1'b1;
      word_cnt_r <= '0;
    end
    else if (last_word)
    begin
      shift_v_r  <= 1'b0;
      word_cnt_r <= '0;
    end
    else if (word_xfer)
      word_cnt_r <= word_cnt_r + 1'b1;
  end

  // Word 0 leaves first from the low end
  always_ff @(posedge clk_i)
  begin
    if (shift_load)
      shift_r <= fifo_resp.data;
    else if (word_xfer)
      shift_r <= shift_r >> `DMA_WORD_W;
  end

  always_comb
  begin
    data_v_o           = '0;
    data_v_o[head_idx] = shift_v_r;
    for (int i = 0; i < `DMA_NUM_PORTS; i++)
      data_o[i] = shift_r[0];
  end

endmodule

`default_nettype wire

//--- verilog/dma_to_mem_bridge.sv
// Bridge from several cache DMA ports to one block-wide memory command channel
`timescale 1ns/1ps
`default_nettype none
`include "dma_bridge_defs.svh"

module dma_to_mem_bridge
  (input  logic                                          clk_i
  ,input  logic                                          reset_i
  ,input  dma_bridge_pkg::dma_pkt_t [`DMA_NUM_PORTS-1:0] dma_pkt_i
  ,input  logic [`DMA_NUM_PORTS-1:0]                     dma_pkt_v_i
  ,output logic [`DMA_NUM_PORTS-1:0]                     dma_pkt_yumi_o
  ,input  dma_bridge_pkg::word_t [`DMA_NUM_PORTS-1:0]    dma_data_i
  ,input  logic [`DMA_NUM_PORTS-1:0]                     dma_data_v_i
  ,output logic [`DMA_NUM_PORTS-1:0]                     dma_data_yumi_o
  ,output dma_bridge_pkg::word_t [`DMA_NUM_PORTS-1:0]    dma_data_o
  ,output logic [`DMA_NUM_PORTS-1:0]                     dma_data_v_o
  ,input  logic [`DMA_NUM_PORTS-1:0]                     dma_data_ready_i
  ,output dma_bridge_pkg::mem_cmd_t                      mem_cmd_o
  ,output logic                                          mem_cmd_v_o
  ,input  logic                                          mem_cmd_yumi_i
  ,input  dma_bridge_pkg::mem_resp_t                     mem_resp_i
  ,input  logic                                          mem_resp_v_i
  ,output logic                                          mem_resp_ready_o
  );

  logic [`DMA_NUM_PORTS-1:0]                     pkt_fifo_ready;
  logic [`DMA_NUM_PORTS-1:0]                     pkt_fifo_v;
  logic [`DMA_NUM_PORTS-1:0]                     pkt_fifo_yumi;
  dma_bridge_pkg::dma_pkt_t [`DMA_NUM_PORTS-1:0] pkt_fifo_data;

  logic                      arb_v;
  logic                      arb_yumi;
  dma_bridge_pkg::dma_pkt_t  arb_pkt;
  dma_bridge_pkg::port_idx_t arb_idx;

  logic                      tag_v;
  logic                      tag_ready;
  dma_bridge_pkg::port_idx_t tag_idx;

  dma_bridge_pkg::port_idx_t data_idx;
  dma_bridge_pkg::word_t     wr_data;
  logic                      wr_data_v;
  logic                      wr_data_yumi;

  assign dma_pkt_yumi_o = dma_pkt_v_i & pkt_fifo_ready;

  // Packet queue per port hides the gap before write data
  for (genvar i = 0; i < `DMA_NUM_PORTS; i++)
  begin : g_pkt_fifo
    dma_two_fifo
      #(.elem_t(dma_bridge_pkg::dma_pkt_t))
      pkt_fifo
      (.clk_i(clk_i), .reset_i(reset_i)
      ,.v_i(dma_pkt_v_i[i]), .data_i(dma_pkt_i[i]), .ready_o(pkt_fifo_ready[i])
      ,.v_o(pkt_fifo_v[i]), .data_o(pkt_fifo_data[i]), .yumi_i(pkt_fifo_yumi[i])
      );
  end

  dma_rr_arbiter arbiter
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.v_i(pkt_fifo_v), .pkt_i(pkt_fifo_data), .yumi_o(pkt_fifo_yumi)
    ,.v_o(arb_v), .pkt_o(arb_pkt), .idx_o(arb_idx), .yumi_i(arb_yumi)
    );

  dma_cmd_builder builder
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.pkt_v_i(arb_v), .pkt_i(arb_pkt), .idx_i(arb_idx), .pkt_yumi_o(arb_yumi)
    ,.tag_ready_i(tag_ready), .tag_v_o(tag_v), .tag_o(tag_idx), .idx_o(data_idx)
    ,.data_v_i(wr_data_v), .data_i(wr_data), .data_yumi_o(wr_data_yumi)
    ,.cmd_o(mem_cmd_o), .cmd_v_o(mem_cmd_v_o), .cmd_yumi_i(mem_cmd_yumi_i)
    );

  // Write data comes only from the port that won the grant
  always_comb
  begin
    wr_data                   = dma_data_i[data_idx];
    wr_data_v                 = dma_data_v_i[data_idx];
    dma_data_yumi_o           = '0;
    dma_data_yumi_o[data_idx] = wr_data_yumi;
  end

  dma_resp_router router
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.tag_v_i(tag_v), .tag_i(tag_idx), .tag_ready_o(tag_ready)
    ,.resp_v_i(mem_resp_v_i), .resp_i(mem_resp_i), .resp_ready_o(mem_resp_ready_o)
    ,.data_o(dma_data_o), .data_v_o(dma_data_v_o), .data_ready_i(dma_data_ready_i)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
// Free-running testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
  #(parameter int period_ns = 8)
  (output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #(period_ns / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- bench/tb_dma_bridge.sv
// Testbench for the DMA to memory bridge with random ports, memory model and scoreboard
`timescale 1ns/1ps
`default_nettype none
`include "dma_bridge_defs.svh"

module tb_dma_bridge;

  localparam int num_ports     = `DMA_NUM_PORTS;
  localparam int block_words   = `DMA_BLOCK_WORDS;
  localparam int addr_w        = `DMA_ADDR_W;
  localparam int clk_period_ns = 8;
  localparam int drive_delay   = 1;
  localparam int reset_cycles  = 10;
  localparam int pkts_per_port = 30;
  localparam int total_pkts    = num_ports * pkts_per_port;
  localparam int timeout_ns    = total_pkts * 200 * clk_period_ns;

  // One expected read in global command order
  typedef struct packed {
    dma_bridge_pkg::port_idx_t port;
    dma_bridge_pkg::block_t    data;
  } read_exp_t;

  logic                                      clk_i;
  logic                                      reset_i;
  dma_bridge_pkg::dma_pkt_t [num_ports-1:0]  dma_pkt_i;
  logic [num_ports-1:0]                      dma_pkt_v_i;
  logic [num_ports-1:0]                      dma_pkt_yumi_o;
  dma_bridge_pkg::word_t [num_ports-1:0]     dma_data_i;
  logic [num_ports-1:0]                      dma_data_v_i;
  logic [num_ports-1:0]                      dma_data_yumi_o;
  dma_bridge_pkg::word_t [num_ports-1:0]     dma_data_o;
  logic [num_ports-1:0]                      dma_data_v_o;
  logic [num_ports-1:0]                      dma_data_ready_i;
  dma_bridge_pkg::mem_cmd_t                  mem_cmd_o;
  logic                                      mem_cmd_v_o;
  logic                                      mem_cmd_yumi_i;
  dma_bridge_pkg::mem_resp_t                 mem_resp_i;
  logic                                      mem_resp_v_i;
  logic                                      mem_resp_ready_o;

  logic [31:0]               lfsr_r = 32'hb799;
  dma_bridge_pkg::mem_cmd_t  exp_cmd_q [num_ports][$];
  read_exp_t                 exp_read_q [$];
  dma_bridge_pkg::mem_resp_t resp_q [$];
  dma_bridge_pkg::block_t    mem_model [logic [addr_w-1:0]];
  int                        word_idx = 0;
  int                        cmds_seen = 0;
  int                        ports_done = 0;

  tb_clock_gen #(.period_ns(clk_period_ns)) clock_gen (.clk_o(clk_i));

  dma_to_mem_bridge dut
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.dma_pkt_i(dma_pkt_i), .dma_pkt_v_i(dma_pkt_v_i), .dma_pkt_yumi_o(dma_pkt_yumi_o)
    ,.dma_data_i(dma_data_i), .dma_data_v_i(dma_data_v_i), .dma_data_yumi_o(dma_data_yumi_o)
    ,.dma_data_o(dma_data_o), .dma_data_v_o(dma_data_v_o), .dma_data_ready_i(dma_data_ready_i)
    ,.mem_cmd_o(mem_cmd_o), .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_yumi_i(mem_cmd_yumi_i)
    ,.mem_resp_i(mem_resp_i), .mem_resp_v_i(mem_resp_v_i), .mem_resp_ready_o(mem_resp_ready_o)
    );

  // Taps 32, 22, 2 and 1 with one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb     = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Port number in the top bit and a few blocks per port so reads hit writes
  function automatic logic [addr_w-1:0] make_addr(input int p, input logic [31:0] sel);
    logic [addr_w-1:0] a;
    a             = '0;
    a[addr_w-1]   = p[0];
    a[6:4]        = sel[2:0];
    return a;
  endfunction

  // Unwritten blocks read back a pattern of the whole address
  function automatic dma_bridge_pkg::block_t read_block(input logic [addr_w-1:0] a);
    dma_bridge_pkg::block_t b;
    if (mem_model.exists(a))
      return mem_model[a];
    for (int w = 0; w < block_words; w++)
      b[w] = dma_bridge_pkg::word_t'(a) * 32'd2654435761 + dma_bridge_pkg::word_t'(w);
    return b;
  endfunction

  task automatic fail_test(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_cmd(input dma_bridge_pkg::mem_cmd_t got,
                           input dma_bridge_pkg::mem_cmd_t exp);
    if (got.op !== exp.op)
      fail_test($sformatf("[ERROR] mem_cmd_o.op got 0x%0h expected 0x%0h", got.op, exp.op));
    if (got.addr !== exp.addr)
      fail_test($sformatf("[ERROR] mem_cmd_o.addr got 0x%0h expected 0x%0h",
                          got.addr, exp.addr));
    if (got.data !== exp.data)
      fail_test($sformatf("[ERROR] mem_cmd_o.data got 0x%0h expected 0x%0h",
                          got.data, exp.data));
  endtask

  task automatic check_word(input string name, input dma_bridge_pkg::word_t got,
                            input dma_bridge_pkg::word_t exp);
    if (got !== exp)
      fail_test($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      #drive_delay;
    end
  endtask

  // Sends one port's packets with each write followed by its block of words
  task automatic run_port(input int p);
    dma_bridge_pkg::dma_pkt_t pkt;
    dma_bridge_pkg::mem_cmd_t exp;
    dma_bridge_pkg::block_t   blk;
    for (int n = 0; n < pkts_per_port; n++)
    begin
      pkt.write_not_read = (rand_bits(1) != 0);
      pkt.addr           = make_addr(p, rand_bits(3));
      blk                = '0;
      if (pkt.write_not_read)
        for (int w = 0; w < block_words; w++)
          blk[w] = rand_bits(32);
      exp.op   = pkt.write_not_read ? dma_bridge_pkg::MEM_WB : dma_bridge_pkg::MEM_RD;
      exp.addr = pkt.addr;
      exp.data = blk;
      exp_cmd_q[p].push_back(exp);
      idle_cycles(rand_bits(2));
      dma_pkt_i[p]   = pkt;
      dma_pkt_v_i[p] = 1'b1;
      do
        @(posedge clk_i);
      while (dma_pkt_yumi_o[p] !== 1'b1);
      #drive_delay;
      dma_pkt_v_i[p] = 1'b0;
      if (pkt.write_not_read)
      begin
        for (int w = 0; w < block_words; w++)
        begin
          idle_cycles(rand_bits(2));
          dma_data_i[p]   = blk[w];
          dma_data_v_i[p] = 1'b1;
          do
            @(posedge clk_i);
          while (dma_data_yumi_o[p] !== 1'b1);
          #drive_delay;
          dma_data_v_i[p] = 1'b0;
        end
      end
    end
    ports_done++;
  endtask

  for (genvar p = 0; p < num_ports; p++)
  begin : g_port
    initial
    begin
      repeat (reset_cycles + 2) @(posedge clk_i);
      #drive_delay;
      run_port(p);
    end
  end

  // Yumi only while the matching valid is high
  always @(posedge clk_i)
  begin : yumi_checker
    if ((dma_pkt_yumi_o & ~dma_pkt_v_i) !== '0)
      fail_test("Packet yumi raised on a port with no valid packet");
    if ((dma_data_yumi_o & ~dma_data_v_i) !== '0)
      fail_test("Write data yumi raised on a port with no valid word");
  end

  // Accepted commands update memory and queue their response
  always @(posedge clk_i)
  begin : cmd_monitor
    int                        port;
    dma_bridge_pkg::mem_resp_t resp;
    read_exp_t                 rd;
    if (!reset_i && mem_cmd_v_o === 1'b1 && mem_cmd_yumi_i === 1'b1)
    begin
      port = int'(mem_cmd_o.addr[addr_w-1]);
      if (exp_cmd_q[port].size() == 0)
        fail_test($sformatf("Memory command from port %0d with no packet left", port));
      check_cmd(mem_cmd_o, exp_cmd_q[port].pop_front());
      cmds_seen++;
      resp.op = mem_cmd_o.op;
      if (mem_cmd_o.op == dma_bridge_pkg::MEM_WB)
      begin
        mem_model[mem_cmd_o.addr] = mem_cmd_o.data;
        resp.data                 = mem_cmd_o.data;
      end
      else
      begin
        rd.port   = dma_bridge_pkg::port_idx_t'(port);
        rd.data   = read_block(mem_cmd_o.addr);
        resp.data = rd.data;
        exp_read_q.push_back(rd);
      end
      resp_q.push_back(resp);
    end
  end

  // Read words follow global read order with word 0 first
  always @(posedge clk_i)
  begin : read_checker
    if (!reset_i)
    begin
      if (dma_data_v_o != '0 && exp_read_q.size() == 0)
        fail_test("Read data valid while no read is outstanding");
      if (!$onehot0(dma_data_v_o))
        fail_test("Read data valid on more than one port");
      for (int p = 0; p < num_ports; p++)
      begin
        if (dma_data_v_o[p] && dma_data_ready_i[p])
        begin
          if (int'(exp_read_q[0].port) != p)
            fail_test($sformatf("Read word on port %0d, expected port %0d",
                                p, exp_read_q[0].port));
          check_word($sformatf("dma_data_o[%0d]", p), dma_data_o[p],
                     exp_read_q[0].data[word_idx]);
          word_idx++;
          if (word_idx == block_words)
          begin
            word_idx = 0;
            void'(exp_read_q.pop_front());
          end
        end
      end
    end
  end

  // Memory side drivers
  initial
  begin : cmd_yumi_driver
    forever
    begin
      @(posedge clk_i);
      #drive_delay;
      mem_cmd_yumi_i = (mem_cmd_v_o === 1'b1) && (rand_bits(2) != 0);
      dma_data_ready_i = num_ports'(rand_bits(num_ports));
    end
  end

  initial
  begin : resp_driver
    logic sent;
    forever
    begin
      @(posedge clk_i);
      sent = mem_resp_v_i && (mem_resp_ready_o === 1'b1);
      if (sent)
        void'(resp_q.pop_front());
      #drive_delay;
      if (mem_resp_v_i && !sent)
        mem_resp_v_i = 1'b1;
      else if (resp_q.size() > 0 && rand_bits(1) != 0)
      begin
        mem_resp_i   = resp_q[0];
        mem_resp_v_i = 1'b1;
      end
      else
        mem_resp_v_i = 1'b0;
    end
  end

  initial
  begin : watchdog
    #(timeout_ns);
    fail_test("Timeout, the bridge stopped making progress");
  end

  function automatic logic all_done();
    return (ports_done == num_ports) && (cmds_seen == total_pkts) &&
           (exp_read_q.size() == 0) && (resp_q.size() == 0) && !mem_resp_v_i;
  endfunction

  initial
  begin
    reset_i          = 1'b1;
    dma_pkt_i        = '0;
    dma_pkt_v_i      = '0;
    dma_data_i       = '0;
    dma_data_v_i     = '0;
    dma_data_ready_i = '0;
    mem_cmd_yumi_i   = 1'b0;
    mem_resp_i       = '0;
    mem_resp_v_i     = 1'b0;
    repeat (reset_cycles) @(posedge clk_i);
    #drive_delay;
    reset_i = 1'b0;
    while (!all_done())
      @(posedge clk_i);
    // Quiet period catches a stuck command or stray read words
    repeat (50) @(posedge clk_i);
    if (mem_cmd_v_o !== 1'b0 || dma_data_v_o !== '0)
      fail_test("Bridge still active after all packets completed");
    else
      $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/dma_bridge_pkg.sv
verilog/dma_two_fifo.sv
verilog/dma_rr_arbiter.sv
verilog/dma_cmd_builder.sv
verilog/dma_resp_router.sv
verilog/dma_to_mem_bridge.sv
bench/tb_clock_gen.sv
bench/tb_dma_bridge.sv
